// File: source/tomasulo_pkg.sv
package tomasulo_pkg;

  localparam int xlen     = 32;
  localparam int shamt_w  = $clog2(xlen);
  localparam int num_regs = 32;
  localparam int reg_w    = $clog2(num_regs);
  localparam int rs_depth = 4;
  localparam int tag_w    = 3;  // Tag 0 means value present, entry i is tag i+1
  localparam int iq_depth = 4;
  localparam int iq_ptr_w = $clog2(iq_depth);
  localparam int num_alus = 2;

  // RISC-V major opcodes handled by the core
  typedef enum logic [6:0] {
    op_reg = 7'b0110011,
    op_imm = 7'b0010011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_nop  // Dropped at issue
  } alu_func_e;

endpackage

// File: source/issue_if.sv
`timescale 1ns/100ps

interface issue_if import tomasulo_pkg::*; ();
  logic             issue_valid;
  alu_func_e        func;
  logic [xlen-1:0]  vj;
  logic [xlen-1:0]  vk;
  logic [tag_w-1:0] qj;
  logic [tag_w-1:0] qk;
  logic             free;       // At least one entry empty
  logic [tag_w-1:0] alloc_tag;  // Tag given to the next issue

  modport issuer (output issue_valid, func, vj, vk, qj, qk, input free, alloc_tag);
  modport station (input issue_valid, func, vj, vk, qj, qk, output free, alloc_tag);
endinterface

// File: source/instruction_queue.sv
`timescale 1ns/100ps

module instruction_queue import tomasulo_pkg::*; (
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic        push,
  input  logic [31:0] instr,
  input  logic        pop,
  output logic [31:0] head,
  output logic        head_valid,
  output logic        full
);
  logic [31:0]         mem [iq_depth];
  logic [iq_ptr_w-1:0] wr_ptr;
  logic [iq_ptr_w-1:0] rd_ptr;
  logic [iq_ptr_w:0]   count;
  logic                do_push;
  logic                do_pop;

  assign full       = (count == (iq_ptr_w + 1)'(iq_depth));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];
  assign do_push    = push && !full;  // Pushes while full are dropped
  assign do_pop     = pop && head_valid;

  always_ff @(posedge clk_100mhz) begin
    if (do_push) begin
      mem[wr_ptr] <= instr;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + iq_ptr_w'(1);  // Wraps at iq_depth
      if (do_pop) rd_ptr <= rd_ptr + iq_ptr_w'(1);
      if (do_push && !do_pop) begin
        count <= count + (iq_ptr_w + 1)'(1);
      end else if (!do_push && do_pop) begin
        count <= count - (iq_ptr_w + 1)'(1);
      end
    end
  end

  // Issue logic only pops a valid head
  assert property (@(posedge clk_100mhz) disable iff (sys_rst) pop |-> head_valid);

endmodule

// File: source/decode.sv
`timescale 1ns/100ps

module decode import tomasulo_pkg::*; (
  input  logic [31:0]      instr,
  output alu_func_e        func,
  output logic [reg_w-1:0] rs1,
  output logic [reg_w-1:0] rs2,
  output logic [reg_w-1:0] rd,
  output logic [xlen-1:0]  imm,
  output logic             use_imm
);
  logic [2:0] funct3;
  logic       alt;      // funct7 bit 5, picks SUB and SRA
  logic       is_reg;
  alu_func_e  op_func;

  assign funct3  = instr[14:12];
  assign alt     = instr[30];
  assign rs1     = instr[19:15];
  assign rs2     = instr[24:20];
  assign rd      = instr[11:7];
  assign imm     = {{(xlen - 12){instr[31]}}, instr[31:20]};  // I-type, sign extended
  assign is_reg  = (instr[6:0] == op_reg);
  assign use_imm = (instr[6:0] == op_imm);

  always_comb begin
    case (funct3)
      3'b000:  op_func = (alt && is_reg) ? alu_sub : alu_add;  // ADDI has no SUB form
      3'b001:  op_func = alu_sll;
      3'b010:  op_func = alu_slt;
      3'b011:  op_func = alu_sltu;
      3'b100:  op_func = alu_xor;
      3'b101:  op_func = alt ? alu_sra : alu_srl;
      3'b110:  op_func = alu_or;
      default: op_func = alu_and;
    endcase
  end

  // Writes to x0 become NOPs so x0 never gets renamed
  always_comb begin
    if ((!is_reg && !use_imm) || rd == '0) begin
      func = alu_nop;
    end else begin
      func = op_func;
    end
  end

endmodule

// File: source/register_file.sv
`timescale 1ns/100ps

module register_file import tomasulo_pkg::*; (
  input  logic             clk_100mhz,
  input  logic             sys_rst,
  input  logic [reg_w-1:0] rs1,
  input  logic [reg_w-1:0] rs2,
  output logic [xlen-1:0]  rd1,
  output logic [xlen-1:0]  rd2,
  output logic [tag_w-1:0] q1,
  output logic [tag_w-1:0] q2,
  input  logic             rename_en,
  input  logic [reg_w-1:0] rename_rd,
  input  logic [tag_w-1:0] rename_tag,
  input  logic             cdb_valid,
  input  logic [tag_w-1:0] cdb_tag,
  input  logic [xlen-1:0]  cdb_data,
  input  logic [reg_w-1:0] dbg_addr,
  output logic [xlen-1:0]  dbg_data,
  output logic             dbg_busy
);
  logic [xlen-1:0]  value [num_regs];
  logic             busy  [num_regs];
  logic [tag_w-1:0] tag   [num_regs];
  logic             hit1;
  logic             hit2;

  // Same-cycle broadcast to a pending source is forwarded
  assign hit1 = cdb_valid && busy[rs1] && (tag[rs1] == cdb_tag);
  assign hit2 = cdb_valid && busy[rs2] && (tag[rs2] == cdb_tag);
  assign rd1  = hit1 ? cdb_data : value[rs1];
  assign rd2  = hit2 ? cdb_data : value[rs2];
  assign q1   = (busy[rs1] && !hit1) ? tag[rs1] : '0;
  assign q2   = (busy[rs2] && !hit2) ? tag[rs2] : '0;

  assign dbg_data = value[dbg_addr];
  assign dbg_busy = busy[dbg_addr];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < num_regs; i++) begin
        value[i] <= '0;
        busy[i]  <= 1'b0;
        tag[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < num_regs; i++) begin
        // Stale producers no longer match, so the newest write wins
        if (cdb_valid && busy[i] && tag[i] == cdb_tag) begin
          value[i] <= cdb_data;
          busy[i]  <= 1'b0;
        end
        if (rename_en && rename_rd == reg_w'(i)) begin  // Overrides a same-cycle write
          busy[i] <= 1'b1;
          tag[i]  <= rename_tag;
        end
      end
    end
  end

  // Decoder turns rd == x0 into a NOP
  assert property (@(posedge clk_100mhz) disable iff (sys_rst) !busy[0]);

endmodule

// File: source/alu.sv
`timescale 1ns/100ps

module alu import tomasulo_pkg::*; (
  input  logic             clk_100mhz,
  input  logic             sys_rst,
  input  logic             start,
  input  alu_func_e        func,
  input  logic [xlen-1:0]  op_a,
  input  logic [xlen-1:0]  op_b,
  input  logic [tag_w-1:0] tag_in,
  input  logic             grant,
  output logic             done,
  output logic [tag_w-1:0] res_tag,
  output logic [xlen-1:0]  result,
  output logic             idle
);
  logic [xlen-1:0]    value;
  logic [shamt_w-1:0] shamt;

  assign shamt = op_b[shamt_w-1:0];
  assign idle  = !done;  // Busy until the result is on the CDB

  always_comb begin
    case (func)
      alu_add:  value = op_a + op_b;
      alu_sub:  value = op_a - op_b;
      alu_and:  value = op_a & op_b;
      alu_or:   value = op_a | op_b;
      alu_xor:  value = op_a ^ op_b;
      alu_sll:  value = op_a << shamt;
      alu_srl:  value = op_a >> shamt;
      alu_sra:  value = $signed(op_a) >>> shamt;
      alu_slt:  value = {{(xlen - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: value = {{(xlen - 1){1'b0}}, op_a < op_b};
      default:  value = '0;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (start) begin
      result  <= value;
      res_tag <= tag_in;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      done <= 1'b0;
    end else if (start) begin
      done <= 1'b1;
    end else if (grant) begin
      done <= 1'b0;
    end
  end

endmodule

// File: source/reservation_station.sv
`timescale 1ns/100ps

module reservation_station import tomasulo_pkg::*; (
  input  logic             clk_100mhz,
  input  logic             sys_rst,
  issue_if.station         iss,
  output logic             alu0_start,
  output alu_func_e        alu0_func,
  output logic [xlen-1:0]  alu0_op_a,
  output logic [xlen-1:0]  alu0_op_b,
  output logic [tag_w-1:0] alu0_tag_in,
  input  logic             alu0_done,
  input  logic [tag_w-1:0] alu0_res_tag,
  input  logic [xlen-1:0]  alu0_result,
  input  logic             alu0_idle,
  output logic             alu0_grant,
  output logic             alu1_start,
  output alu_func_e        alu1_func,
  output logic [xlen-1:0]  alu1_op_a,
  output logic [xlen-1:0]  alu1_op_b,
  output logic [tag_w-1:0] alu1_tag_in,
  input  logic             alu1_done,
  input  logic [tag_w-1:0] alu1_res_tag,
  input  logic [xlen-1:0]  alu1_result,
  input  logic             alu1_idle,
  output logic             alu1_grant,
  output logic             cdb_valid,
  output logic [tag_w-1:0] cdb_tag,
  output logic [xlen-1:0]  cdb_data
);
  logic             busy       [rs_depth];
  logic             dispatched [rs_depth];
  alu_func_e        func       [rs_depth];
  logic [xlen-1:0]  vj         [rs_depth];
  logic [xlen-1:0]  vk         [rs_depth];
  logic [tag_w-1:0] qj         [rs_depth];
  logic [tag_w-1:0] qk         [rs_depth];
  logic             ready      [rs_depth];
  logic             avail0;
  logic             avail1;
  logic             pick0_v;
  logic             pick1_v;
  logic [tag_w-1:0] pick0_tag;
  logic [tag_w-1:0] pick1_tag;

  // CDB arbitration, ALU 0 wins
  assign alu0_grant = alu0_done;
  assign alu1_grant = alu1_done && !alu0_done;
  assign cdb_valid  = alu0_done || alu1_done;
  assign cdb_tag    = alu0_done ? alu0_res_tag : alu1_res_tag;
  assign cdb_data   = alu0_done ? alu0_result : alu1_result;

  // Lowest free entry
  always_comb begin
    iss.free      = 1'b0;
    iss.alloc_tag = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        iss.free      = 1'b1;
        iss.alloc_tag = tag_w'(i + 1);
      end
    end
  end

  // A started ALU still reads idle for one cycle
  assign avail0 = alu0_idle && !alu0_start;
  assign avail1 = alu1_idle && !alu1_start;

  always_comb begin
    pick0_v   = 1'b0;
    pick1_v   = 1'b0;
    pick0_tag = '0;
    pick1_tag = '0;
    for (int i = 0; i < rs_depth; i++) begin
      ready[i] = busy[i] && !dispatched[i] && qj[i] == '0 && qk[i] == '0;
      if (ready[i] && avail0 && !pick0_v) begin
        pick0_v   = 1'b1;
        pick0_tag = tag_w'(i + 1);
      end else if (ready[i] && avail1 && !pick1_v) begin
        pick1_v   = 1'b1;
        pick1_tag = tag_w'(i + 1);
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < rs_depth; i++) begin
        busy[i]       <= 1'b0;
        dispatched[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < rs_depth; i++) begin
        if (cdb_valid && cdb_tag == tag_w'(i + 1)) begin  // Freed only on broadcast
          busy[i]       <= 1'b0;
          dispatched[i] <= 1'b0;
        end
        if ((pick0_v && pick0_tag == tag_w'(i + 1)) ||
            (pick1_v && pick1_tag == tag_w'(i + 1))) begin
          dispatched[i] <= 1'b1;
        end
        if (iss.issue_valid && iss.alloc_tag == tag_w'(i + 1)) busy[i] <= 1'b1;
      end
    end
  end

  // Operand capture and wake-up
  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < rs_depth; i++) begin
      if (cdb_valid && qj[i] == cdb_tag) begin
        vj[i] <= cdb_data;
        qj[i] <= '0;
      end
      if (cdb_valid && qk[i] == cdb_tag) begin
        vk[i] <= cdb_data;
        qk[i] <= '0;
      end
      if (iss.issue_valid && iss.alloc_tag == tag_w'(i + 1)) begin
        func[i] <= iss.func;
        vj[i]   <= iss.vj;
        vk[i]   <= iss.vk;
        qj[i]   <= iss.qj;  // Already forwarded for a same-cycle broadcast
        qk[i]   <= iss.qk;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      alu0_start <= 1'b0;
      alu1_start <= 1'b0;
    end else begin
      alu0_start <= pick0_v;
      alu1_start <= pick1_v;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < rs_depth; i++) begin
      if (pick0_v && pick0_tag == tag_w'(i + 1)) begin
        alu0_func <= func[i];
        alu0_op_a <= vj[i];
        alu0_op_b <= vk[i];
      end
      if (pick1_v && pick1_tag == tag_w'(i + 1)) begin
        alu1_func <= func[i];
        alu1_op_a <= vj[i];
        alu1_op_b <= vk[i];
      end
    end
    alu0_tag_in <= pick0_tag;
    alu1_tag_in <= pick1_tag;
  end

  // One entry never ends up held in both ALUs
  assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    alu0_done && alu1_done |-> alu0_res_tag != alu1_res_tag);
  // Top-level issue path honors the free level
  assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    iss.issue_valid |-> iss.free);

endmodule

// File: source/ooo_core.sv
`timescale 1ns/100ps

module ooo_core import tomasulo_pkg::*; (
  input  logic             clk_100mhz,
  input  logic             sys_rst,
  input  logic             instr_valid,
  input  logic [31:0]      instr,
  output logic             iq_full,
  input  logic [reg_w-1:0] dbg_addr,
  output logic [xlen-1:0]  dbg_data,
  output logic             dbg_busy,
  output logic             cdb_valid,
  output logic [tag_w-1:0] cdb_tag,
  output logic [xlen-1:0]  cdb_data
);
  logic [31:0]      head;
  logic             head_valid;
  logic             pop;
  alu_func_e        head_func;
  logic [reg_w-1:0] rs1;
  logic [reg_w-1:0] rs2;
  logic [reg_w-1:0] rd;
  logic [xlen-1:0]  imm;
  logic             use_imm;
  logic [xlen-1:0]  rd1;
  logic [xlen-1:0]  rd2;
  logic [tag_w-1:0] q1;
  logic [tag_w-1:0] q2;

  // Station to ALU links
  logic             a_start   [num_alus];
  alu_func_e        a_func    [num_alus];
  logic [xlen-1:0]  a_op_a    [num_alus];
  logic [xlen-1:0]  a_op_b    [num_alus];
  logic [tag_w-1:0] a_tag_in  [num_alus];
  logic             a_done    [num_alus];
  logic [tag_w-1:0] a_res_tag [num_alus];
  logic [xlen-1:0]  a_result  [num_alus];
  logic             a_idle    [num_alus];
  logic             a_grant   [num_alus];

  issue_if iss ();

  instruction_queue u_iq (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .push(instr_valid), .instr(instr),
    .pop(pop), .head(head), .head_valid(head_valid), .full(iq_full)
  );

  decode u_decode (
    .instr(head), .func(head_func), .rs1(rs1), .rs2(rs2), .rd(rd),
    .imm(imm), .use_imm(use_imm)
  );

  assign iss.issue_valid = head_valid && (head_func != alu_nop) && iss.free;
  assign pop     = iss.issue_valid || (head_valid && head_func == alu_nop);  // NOPs just drain
  assign iss.func = head_func;
  assign iss.vj   = rd1;
  assign iss.qj   = q1;
  assign iss.vk   = use_imm ? imm : rd2;
  assign iss.qk   = use_imm ? '0 : q2;

  register_file u_rf (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .rs1(rs1), .rs2(rs2),
    .rd1(rd1), .rd2(rd2), .q1(q1), .q2(q2),
    .rename_en(iss.issue_valid), .rename_rd(rd), .rename_tag(iss.alloc_tag),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
    .dbg_addr(dbg_addr), .dbg_data(dbg_data), .dbg_busy(dbg_busy)
  );

  reservation_station u_rs (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .iss(iss.station),
    .alu0_start(a_start[0]), .alu0_func(a_func[0]), .alu0_op_a(a_op_a[0]),
    .alu0_op_b(a_op_b[0]), .alu0_tag_in(a_tag_in[0]), .alu0_done(a_done[0]),
    .alu0_res_tag(a_res_tag[0]), .alu0_result(a_result[0]), .alu0_idle(a_idle[0]),
    .alu0_grant(a_grant[0]),
    .alu1_start(a_start[1]), .alu1_func(a_func[1]), .alu1_op_a(a_op_a[1]),
    .alu1_op_b(a_op_b[1]), .alu1_tag_in(a_tag_in[1]), .alu1_done(a_done[1]),
    .alu1_res_tag(a_res_tag[1]), .alu1_result(a_result[1]), .alu1_idle(a_idle[1]),
    .alu1_grant(a_grant[1]),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
  );

  for (genvar g = 0; g < num_alus; g++) begin : g_alu
    alu u_alu (
      .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .start(a_start[g]), .func(a_func[g]),
      .op_a(a_op_a[g]), .op_b(a_op_b[g]), .tag_in(a_tag_in[g]), .grant(a_grant[g]),
      .done(a_done[g]), .res_tag(a_res_tag[g]), .result(a_result[g]), .idle(a_idle[g])
    );
  end

endmodule

// File: verif/ooo_core_tb.sv
`timescale 1ns/100ps

module ooo_core_tb;
  localparam logic [6:0] op_reg_code = 7'b0110011;
  localparam logic [6:0] op_imm_code = 7'b0010011;
  localparam int f3_add = 0;
  localparam int f3_sll = 1;
  localparam int f3_slt = 2;
  localparam int f3_sltu = 3;
  localparam int f3_xor = 4;
  localparam int f3_sr = 5;
  localparam int f3_or = 6;
  localparam int f3_and = 7;
  localparam int wait_limit = 200;

  logic        clk_100mhz;
  logic        sys_rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic        iq_full;
  logic [4:0]  dbg_addr;
  logic [31:0] dbg_data;
  logic        dbg_busy;
  logic        cdb_valid;
  logic [2:0]  cdb_tag;
  logic [31:0] cdb_data;

  logic [31:0] model_regs [32];
  logic [31:0] prog [$];
  string       test_name [$];
  int          prog_first [$];
  int          prog_len [$];
  logic [31:0] check_mask [$];
  logic [31:0] pending_results [$];  // Model results not yet seen on the CDB
  int          bcast_count;
  int          expected_bcasts;
  int          checks;
  int          errors;
  int unsigned seed_init;

  ooo_core dut (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .instr_valid(instr_valid), .instr(instr),
    .iq_full(iq_full), .dbg_addr(dbg_addr), .dbg_data(dbg_data), .dbg_busy(dbg_busy),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  // Station tags run from 1 to 4 and each value must be an outstanding result
  task automatic match_broadcast(input logic [2:0] tag, input logic [31:0] data);
    int idx;
    idx = -1;
    if (tag == 3'd0 || tag > 3'd4) begin
      errors++;
      $display("ERROR: broadcast tag %0d is outside the station tag range", tag);
    end
    for (int i = 0; i < pending_results.size(); i++) begin
      if (idx < 0 && pending_results[i] === data) idx = i;
    end
    if (idx < 0) begin
      errors++;
      $display("ERROR: broadcast value %h matches no outstanding result", data);
    end else begin
      pending_results.delete(idx);
    end
  endtask

  // One broadcast per executed instruction
  always @(posedge clk_100mhz) begin
    if (sys_rst) begin
      bcast_count <= 0;
    end else if (cdb_valid) begin
      bcast_count <= bcast_count + 1;
      match_broadcast(cdb_tag, cdb_data);
    end
  end

  function automatic logic [31:0] enc_r(input int f3, input bit alt, input int rd,
                                        input int rs1, input int rs2);
    return {1'b0, alt, 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg_code};
  endfunction

  function automatic logic [31:0] enc_i(input int f3, input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op_imm_code};
  endfunction

  // In-order RISC-V reference that returns 1 when a register gets written
  function automatic bit model_exec(input logic [31:0] w);
    logic        is_imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [4:0]  sh;
    is_imm = (w[6:0] == op_imm_code);
    a      = model_regs[w[19:15]];
    b      = is_imm ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
    sh     = b[4:0];
    case (w[14:12])
      3'd0: r = (!is_imm && w[30]) ? a - b : a + b;
      3'd1: r = a << sh;
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (w[30]) r = $signed(a) >>> sh;
        else r = a >> sh;
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    if (!(is_imm || w[6:0] == op_reg_code) || w[11:7] == 5'd0) return 1'b0;  // NOP
    model_regs[w[11:7]] = r;
    return 1'b1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic start_test(input string name, input logic [31:0] mask);
    test_name.push_back(name);
    prog_first.push_back(prog.size());
    prog_len.push_back(0);
    check_mask.push_back(mask);
  endtask

  task automatic add_instr(input logic [31:0] w);
    prog.push_back(w);
    prog_len[prog_len.size() - 1] += 1;
  endtask

  task automatic build_table();
    int  f3;
    bit  alt;
    start_test("imm_ops", 32'h0000_007e);
    add_instr(enc_i(f3_add, 1, 0, 100));
    add_instr(enc_i(f3_add, 2, 0, -7));
    add_instr(enc_i(f3_xor, 3, 0, 'h5a5));
    add_instr(enc_i(f3_slt, 4, 0, 5));
    add_instr(enc_i(f3_sr, 5, 2, 'h402));  // SRAI by 2
    add_instr(enc_i(f3_xor, 6, 2, -1));
    start_test("raw_chain", 32'h0000_1f80);
    add_instr(enc_i(f3_add, 7, 0, 3));
    add_instr(enc_r(f3_add, 1'b0, 8, 7, 7));
    add_instr(enc_r(f3_add, 1'b1, 9, 8, 7));  // SUB
    add_instr(enc_r(f3_sll, 1'b0, 10, 9, 7));
    add_instr(enc_r(f3_or, 1'b0, 11, 10, 8));
    add_instr(enc_r(f3_sr, 1'b0, 12, 11, 7));
    start_test("waw", 32'h0000_6000);
    add_instr(enc_i(f3_add, 13, 0, 1));
    add_instr(enc_i(f3_add, 13, 0, 2));
    add_instr(enc_r(f3_add, 1'b0, 14, 13, 13));
    add_instr(enc_i(f3_add, 13, 0, 3));
    add_instr(enc_i(f3_xor, 13, 13, 12));
    start_test("backpressure", 32'h007f_8000);
    add_instr(enc_i(f3_add, 15, 0, 11));
    add_instr(enc_i(f3_add, 16, 0, -20));
    add_instr(enc_r(f3_add, 1'b0, 17, 15, 16));
    add_instr(enc_r(f3_add, 1'b1, 18, 16, 15));
    add_instr(enc_r(f3_and, 1'b0, 19, 17, 18));
    add_instr(enc_r(f3_or, 1'b0, 20, 15, 16));
    add_instr(enc_r(f3_xor, 1'b0, 21, 20, 17));
    add_instr(enc_r(f3_slt, 1'b0, 22, 16, 15));
    add_instr(enc_r(f3_sltu, 1'b0, 15, 16, 15));  // Overwrites a source of earlier ops
    add_instr(enc_r(f3_sr, 1'b1, 16, 16, 22));
    add_instr(enc_r(f3_add, 1'b0, 17, 17, 17));
    add_instr(enc_r(f3_sr, 1'b0, 18, 18, 22));
    start_test("x0_and_nops", 32'h0080_007f);
    add_instr(enc_i(f3_add, 0, 0, 55));
    add_instr(enc_r(f3_add, 1'b0, 0, 1, 2));
    add_instr({20'h12345, 5'd1, 7'b0110111});  // LUI x1
    add_instr({12'h000, 5'd1, 3'b010, 5'd2, 7'b0000011});  // LW x2
    add_instr(enc_i(f3_add, 23, 0, 9));
    start_test("random_ops", 32'hffff_ffff);
    for (int i = 1; i <= 4; i++) begin
      add_instr(enc_i(f3_add, i, 0, int'($urandom_range(4095))));
    end
    for (int i = 0; i < 20; i++) begin
      f3  = int'($urandom_range(7));
      alt = (f3 == f3_add || f3 == f3_sr) && ($urandom_range(1) == 1);
      add_instr(enc_r(f3, alt, int'($urandom_range(7, 1)), int'($urandom_range(7)),
                      int'($urandom_range(7))));
    end
  endtask

  // Holds the word until the queue takes it
  task automatic push_instr(input logic [31:0] w);
    int n;
    instr_valid <= 1'b1;
    instr       <= w;
    n = 0;
    do begin
      @(posedge clk_100mhz);
      n++;
    end while (iq_full && n < wait_limit);
    if (iq_full) begin
      errors++;
      $display("ERROR: instruction queue stayed full, word %h not accepted", w);
    end
  endtask

  task automatic wait_broadcasts(input int target);
    int n;
    n = 0;
    while (bcast_count < target && n < wait_limit) begin
      @(posedge clk_100mhz);
      n++;
    end
    if (bcast_count < target) begin
      errors++;
      $display("ERROR: timeout, only %0d of %0d results were broadcast", bcast_count, target);
    end
  endtask

  task automatic read_reg(input int r, output logic [31:0] data);
    int n;
    dbg_addr <= r[4:0];
    @(posedge clk_100mhz);
    n = 0;
    while (dbg_busy && n < wait_limit) begin
      @(posedge clk_100mhz);
      n++;
    end
    if (dbg_busy) begin
      errors++;
      $display("ERROR: register x%0d never lost its busy bit", r);
    end
    data = dbg_data;
  endtask

  task automatic run_test(input int t);
    logic [31:0] data;
    logic [31:0] w;
    for (int i = 0; i < prog_len[t]; i++) begin
      w = prog[prog_first[t] + i];
      if (model_exec(w)) begin
        expected_bcasts++;
        pending_results.push_back(model_regs[w[11:7]]);
      end
      push_instr(w);
    end
    instr_valid <= 1'b0;
    wait_broadcasts(expected_bcasts);
    for (int r = 0; r < 32; r++) begin
      read_reg(r, data);
      if (check_mask[t][r]) begin
        check_value($sformatf("%s x%0d", test_name[t], r), model_regs[r], data);
      end
    end
    check_value({test_name[t], " broadcasts"}, expected_bcasts, bcast_count);  // Exactly once
  endtask

  initial begin
    seed_init       = $urandom(32'hae9);
    sys_rst         = 1'b1;
    instr_valid     = 1'b0;
    instr           = '0;
    dbg_addr        = '0;
    checks          = 0;
    errors          = 0;
    expected_bcasts = 0;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    build_table();
    repeat (4) @(posedge clk_100mhz);
    sys_rst <= 1'b0;
    @(posedge clk_100mhz);
    for (int t = 0; t < test_name.size(); t++) run_test(t);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
source/tomasulo_pkg.sv
source/issue_if.sv
source/instruction_queue.sv
source/decode.sv
source/register_file.sv
source/alu.sv
source/reservation_station.sv
source/ooo_core.sv
verif/ooo_core_tb.sv

// File: Makefile
# Verilator build and run for the out-of-order core testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module ooo_core_tb -f vlog.f -Mdir obj_dir

# Fails unless the pass message shows up as a line of its own
run: compile
	@out="$$(./obj_dir/Vooo_core_tb)"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
